/* hdl/gtiaDisplay_cfg.svh */
// Widths of the video path, sized for a screen of at most 320 x 192 pixels
// The display buffer must hold y * width + x within GTIA_ADDR_BITS
`ifndef GTIA_DISPLAY_CFG_SVH
`define GTIA_DISPLAY_CFG_SVH

// Screen coordinates
`define GTIA_X_BITS 9
`define GTIA_Y_BITS 8

// Display buffer address, one word per pixel
`define GTIA_ADDR_BITS 16

// Color widths
`define GTIA_RGB_BITS 24

// Buffer word carries RGB in the low three bytes and zero above
`define GTIA_BUF_BITS 32

`endif

/* hdl/gtiaRegPkg.sv */
// Register-side types of the GTIA color path
// Only the normal priority mode produces pixels
`default_nettype none
`include "gtiaDisplay_cfg.svh"

package gtiaRegPkg;

  // ANTIC pixel codes, 9 to 15 carry nothing
  typedef enum logic [3:0] {
    noTransmission = 4'd0,
    vSync          = 4'd1,
    hBlankC40      = 4'd2,
    hBlankS40      = 4'd3,
    bgColor        = 4'd4,
    playfield0     = 4'd5,
    playfield1     = 4'd6,
    playfield2     = 4'd7,
    playfield3     = 4'd8
  } anCode;

  // PRIOR bits 7:6
  typedef enum logic [1:0] {
    modeNormal = 2'd0,
    modeGtia1  = 2'd1,
    modeGtia2  = 2'd2,
    modeGtia3  = 2'd3
  } priorMode;

  // Color register layout
  typedef struct packed {
    logic [3:0] hue;
    logic [2:0] lum;
    logic       spare;
  } colorByte;

  // Brightest RGB for each hue, scaled down by luminance
  localparam logic [`GTIA_RGB_BITS-1:0] hueBase [16] = '{
    24'hFFFFFF, 24'hE0C040, 24'hF0A040, 24'hF08060,
    24'hF070A0, 24'hD060D0, 24'hA070F0, 24'h7080F0,
    24'h50A0F0, 24'h40C0F0, 24'h40E0D0, 24'h40E0A0,
    24'h60F060, 24'hA0F040, 24'hD0D040, 24'hF0B050
  };

endpackage

`default_nettype wire

/* hdl/gtiaScanPkg.sv */
// Scan-side types of the screen walker
// Repeats of four and eight lines are walked as one
`default_nettype none

package gtiaScanPkg;

  // Order in which pixels land on screen, code 3 acts as lineOrder
  typedef enum logic [1:0] {
    lineOrder = 2'd0,
    block8    = 2'd1,
    block16   = 2'd2
  } scanOrder;

  // Scan lines per mode line
  typedef enum logic [1:0] {
    one   = 2'd0,
    two   = 2'd1,
    four  = 2'd2,
    eight = 2'd3
  } lineRepeat;

endpackage

`default_nettype wire

/* hdl/gtiaIf.sv */
// Buses inside the video path
// Both carry no clock, every endpoint samples on Fphi0
`timescale 1ns/1ns
`default_nettype none
`include "gtiaDisplay_cfg.svh"

// One pixel per pixValid strobe
interface pixIf;
  logic                 pixValid;
  gtiaRegPkg::colorByte color;

  modport producer (output pixValid, output color);
  modport consumer (input pixValid, input color);
  // Walker needs only the step strobe
  modport stepper (input pixValid);
endinterface

// Current screen position and its end flags
interface posIf;
  logic [`GTIA_X_BITS-1:0] x;
  logic [`GTIA_Y_BITS-1:0] y;
  // Levels for the current position
  logic                    lineEnd;
  logic                    frameEnd;

  modport source (
    output x,
    output y,
    output lineEnd,
    output frameEnd
  );
  modport sink (
    input x,
    input y,
    input lineEnd,
    input frameEnd
  );
endinterface

`default_nettype wire

/* hdl/anDecoder.sv */
// Samples AN every Fphi0 edge and selects the color register in normal mode
// GTIA modes 1 to 3 yield no pixels
`timescale 1ns/1ns
`default_nettype none

module anDecoder (
  input  wire logic                 Fphi0,
  input  wire logic                 rst,
  input  wire gtiaRegPkg::anCode    AN,
  input  wire logic [7:0]           prior,
  input  wire gtiaRegPkg::colorByte colbk,
  input  wire gtiaRegPkg::colorByte colpf0,
  input  wire gtiaRegPkg::colorByte colpf1,
  input  wire gtiaRegPkg::colorByte colpf2,
  input  wire gtiaRegPkg::colorByte colpf3,
  pixIf.producer                    pix
);

  gtiaRegPkg::priorMode mode;
  gtiaRegPkg::colorByte selColor;
  logic                 selValid;

  assign mode = gtiaRegPkg::priorMode'(prior[7:6]);

  always_comb begin
    selValid = 1'b0;
    selColor = colbk;
    if (mode == gtiaRegPkg::modeNormal) begin
      case (AN)
        gtiaRegPkg::bgColor: begin
          selValid = 1'b1;
          selColor = colbk;
        end
        gtiaRegPkg::playfield0: begin
          selValid = 1'b1;
          selColor = colpf0;
        end
        gtiaRegPkg::playfield1: begin
          selValid = 1'b1;
          selColor = colpf1;
        end
        gtiaRegPkg::playfield2: begin
          selValid = 1'b1;
          selColor = colpf2;
        end
        gtiaRegPkg::playfield3: begin
          selValid = 1'b1;
          selColor = colpf3;
        end
        // Sync, blank and unused codes draw nothing
        default: selValid = 1'b0;
      endcase
    end
  end

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      pix.pixValid <= 1'b0;
    end else begin
      pix.pixValid <= selValid;
    end
  end

  // Color holds its last value between pixels
  always_ff @(posedge Fphi0) begin
    if (selValid) begin
      pix.color <= selColor;
    end
  end

endmodule

`default_nettype wire

/* hdl/colorTable.sv */
// Color byte to 24-bit RGB, purely combinational
// Each channel is base * (lum + 1) / 8, truncated
`timescale 1ns/1ns
`default_nettype none
`include "gtiaDisplay_cfg.svh"

module colorTable (
  input  wire gtiaRegPkg::colorByte     color,
  output logic [`GTIA_RGB_BITS-1:0]     rgb
);

  localparam int Channels = `GTIA_RGB_BITS / 8;

  logic [`GTIA_RGB_BITS-1:0] base;
  logic [3:0]                lumScale;
  logic [10:0]               scaled;

  assign base     = gtiaRegPkg::hueBase[color.hue];
  assign lumScale = {1'b0, color.lum} + 4'd1;

  always_comb begin
    rgb    = '0;
    scaled = '0;
    for (int ch = 0; ch < Channels; ch++) begin
      scaled = base[ch*8 +: 8] * lumScale;
      // Divide by 8, lum 7 returns the base
      rgb[ch*8 +: 8] = scaled[10:3];
    end
  end

endmodule

`default_nettype wire

/* hdl/scanWalker.sv */
// Screen position walker for line, 8x8 block and 16x16 block scan orders
// Block orders expect width and height in whole blocks
`timescale 1ns/1ns
`default_nettype none
`include "gtiaDisplay_cfg.svh"

module scanWalker (
  input  wire logic                     Fphi0,
  input  wire logic                     rst,
  input  wire logic                     DLISTend,
  input  wire gtiaScanPkg::scanOrder    charMode,
  input  wire gtiaScanPkg::lineRepeat   numLines,
  input  wire logic [`GTIA_X_BITS-1:0]  width,
  input  wire logic [`GTIA_Y_BITS-1:0]  height,
  pixIf.stepper                         pix,
  posIf.source                          pos
);

  logic [`GTIA_X_BITS-1:0] xMax;
  logic [`GTIA_Y_BITS-1:0] yMax;
  logic                    xLast;
  logic                    groupEnd;
  logic                    atFrameEnd;
  logic [`GTIA_X_BITS-1:0] xNext;
  logic [`GTIA_Y_BITS-1:0] yNext;

  assign xMax       = width - 1'b1;
  assign yMax       = height - 1'b1;
  assign xLast      = (pos.x == xMax);
  assign atFrameEnd = xLast && (pos.y == yMax);

  assign pos.lineEnd  = groupEnd;
  assign pos.frameEnd = atFrameEnd;

  // Next position, default is one step right
  always_comb begin
    xNext    = pos.x + 1'b1;
    yNext    = pos.y;
    groupEnd = xLast;
    case (charMode)
      gtiaScanPkg::block8: begin
        groupEnd = xLast && (pos.y[2:0] == 3'd7);
        if (groupEnd) begin
          xNext = '0;
          yNext = pos.y + 1'b1;
        end else if (pos.x[2:0] == 3'd7) begin
          if (pos.y[2:0] == 3'd7) begin
            // Block done, top row of the block to the right
            yNext = pos.y - 3'd7;
          end else begin
            xNext = pos.x - 3'd7;
            yNext = pos.y + 1'b1;
          end
        end
      end
      gtiaScanPkg::block16: begin
        groupEnd = xLast && (pos.y[3:0] == 4'hF);
        if (groupEnd) begin
          xNext = '0;
          yNext = pos.y + 1'b1;
        end else if (!pos.y[0]) begin
          // Top pixel of a 2x2 column goes down
          xNext = pos.x;
          yNext = pos.y + 1'b1;
        end else if (pos.x[3:0] != 4'hF) begin
          // Up and right, within or into the next mini-block
          yNext = pos.y - 1'b1;
        end else if (pos.y[3:0] == 4'hF) begin
          yNext = pos.y - 4'd15;
        end else begin
          // Next band of mini-blocks in the same block
          xNext = pos.x - 4'd15;
          yNext = pos.y + 1'b1;
        end
      end
      default: begin
        if (numLines == gtiaScanPkg::two) begin
          groupEnd = xLast && pos.y[0];
          if (!pos.y[0]) begin
            xNext = pos.x;
            yNext = pos.y + 1'b1;
          end else if (xLast) begin
            xNext = '0;
            yNext = pos.y + 1'b1;
          end else begin
            yNext = pos.y - 1'b1;
          end
        end else if (xLast) begin
          xNext = '0;
          yNext = pos.y + 1'b1;
        end
      end
    endcase
  end

  // DLISTend wins over a step
  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      pos.x <= '0;
      pos.y <= '0;
    end else if (DLISTend) begin
      pos.x <= '0;
      pos.y <= '0;
    end else if (pix.pixValid) begin
      if (atFrameEnd) begin
        pos.x <= '0;
        pos.y <= '0;
      end else begin
        pos.x <= xNext;
        pos.y <= yNext;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/bufferWriter.sv */
// Registers one display buffer write per pixel strobe
// The buffer must take a write every cycle, there is no stall
`timescale 1ns/1ns
`default_nettype none
`include "gtiaDisplay_cfg.svh"

module bufferWriter (
  input  wire logic                     Fphi0,
  input  wire logic                     rst,
  input  wire logic [`GTIA_X_BITS-1:0]  width,
  pixIf.consumer                        pix,
  posIf.sink                            pos,
  output logic [`GTIA_BUF_BITS-1:0]     dBufData,
  output logic [`GTIA_ADDR_BITS-1:0]    dBufAddr,
  output logic                          dBufWriteEn,
  output logic                          hblank,
  output logic                          vblank,
  output logic [`GTIA_X_BITS-1:0]       x,
  output logic [`GTIA_Y_BITS-1:0]       y
);

  logic [`GTIA_RGB_BITS-1:0]              rgb;
  logic [`GTIA_X_BITS+`GTIA_Y_BITS-1:0]   linAddr;

  colorTable colorConv (
    .color (pix.color),
    .rgb   (rgb)
  );

  // Row-major buffer address
  assign linAddr = pos.y * width + pos.x;

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      dBufWriteEn <= 1'b0;
      hblank      <= 1'b0;
      vblank      <= 1'b0;
      x           <= '0;
      y           <= '0;
    end else begin
      dBufWriteEn <= pix.pixValid;
      hblank      <= pix.pixValid && pos.lineEnd;
      vblank      <= pix.pixValid && pos.frameEnd;
      if (pix.pixValid) begin
        x <= pos.x;
        y <= pos.y;
      end
    end
  end

  always_ff @(posedge Fphi0) begin
    if (pix.pixValid) begin
      dBufData <= {{(`GTIA_BUF_BITS-`GTIA_RGB_BITS){1'b0}}, rgb};
      dBufAddr <= linAddr[`GTIA_ADDR_BITS-1:0];
    end
  end

endmodule

`default_nettype wire

/* hdl/gtiaVideo.sv */
// GTIA pixel output path, AN code in and display buffer writes out
// Writes trail the AN sample by two Fphi0 edges
`timescale 1ns/1ns
`default_nettype none
`include "gtiaDisplay_cfg.svh"

module gtiaVideo (
  input  wire logic                     Fphi0,
  input  wire logic                     rst,
  input  wire gtiaRegPkg::anCode        AN,
  input  wire logic [7:0]               PRIOR,
  input  wire gtiaRegPkg::colorByte     COLBK,
  input  wire gtiaRegPkg::colorByte     COLPF0,
  input  wire gtiaRegPkg::colorByte     COLPF1,
  input  wire gtiaRegPkg::colorByte     COLPF2,
  input  wire gtiaRegPkg::colorByte     COLPF3,
  input  wire gtiaScanPkg::scanOrder    charMode,
  input  wire gtiaScanPkg::lineRepeat   numLines,
  input  wire logic [`GTIA_X_BITS-1:0]  width,
  input  wire logic [`GTIA_Y_BITS-1:0]  height,
  input  wire logic                     DLISTend,
  output logic [`GTIA_BUF_BITS-1:0]     dBufData,
  output logic [`GTIA_ADDR_BITS-1:0]    dBufAddr,
  output logic                          dBufWriteEn,
  output logic                          hblank,
  output logic                          vblank,
  output logic [`GTIA_X_BITS-1:0]       x,
  output logic [`GTIA_Y_BITS-1:0]       y
);

  pixIf pixBus ();
  posIf posBus ();

  anDecoder anDec (
    .Fphi0  (Fphi0),
    .rst    (rst),
    .AN     (AN),
    .prior  (PRIOR),
    .colbk  (COLBK),
    .colpf0 (COLPF0),
    .colpf1 (COLPF1),
    .colpf2 (COLPF2),
    .colpf3 (COLPF3),
    .pix    (pixBus.producer)
  );

  scanWalker walker (
    .Fphi0    (Fphi0),
    .rst      (rst),
    .DLISTend (DLISTend),
    .charMode (charMode),
    .numLines (numLines),
    .width    (width),
    .height   (height),
    .pix      (pixBus.stepper),
    .pos      (posBus.source)
  );

  bufferWriter writer (
    .Fphi0       (Fphi0),
    .rst         (rst),
    .width       (width),
    .pix         (pixBus.consumer),
    .pos         (posBus.sink),
    .dBufData    (dBufData),
    .dBufAddr    (dBufAddr),
    .dBufWriteEn (dBufWriteEn),
    .hblank      (hblank),
    .vblank      (vblank),
    .x           (x),
    .y           (y)
  );

endmodule

`default_nettype wire

/* tb/tbClock.sv */
// Free-running 20 ns Fphi0 and a reset held over the first two rising edges
`timescale 1ns/1ns
`default_nettype none

module tbClock (
  output logic Fphi0,
  output logic rst
);

  initial begin
    Fphi0 = 1'b0;
    forever #10 Fphi0 = ~Fphi0;
  end

  initial begin
    rst = 1'b1;
    repeat (2) @(posedge Fphi0);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

/* tb/gtiaVideoTb.sv */
// Table-driven testbench with its own model of the walker and color rules
// Color registers are redrawn before every table entry from a fixed seed
`timescale 1ns/1ns
`default_nettype none
`include "gtiaDisplay_cfg.svh"

module gtiaVideoTb;

  typedef struct {
    string      name;
    logic [3:0] an;
    logic [7:0] prior;
    logic [1:0] order;
    logic [1:0] rep;
    int         w;
    int         h;
    bit         dlist;
    int         burst;
  } stimEntry;

  typedef struct {
    string       name;
    logic [31:0] data;
    logic [31:0] addr;
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] hb;
    logic [31:0] vb;
    int          due;
  } expWrite;

  logic                     Fphi0;
  logic                     rst;
  gtiaRegPkg::anCode        AN;
  logic [7:0]               PRIOR;
  gtiaRegPkg::colorByte     COLBK;
  gtiaRegPkg::colorByte     COLPF0;
  gtiaRegPkg::colorByte     COLPF1;
  gtiaRegPkg::colorByte     COLPF2;
  gtiaRegPkg::colorByte     COLPF3;
  gtiaScanPkg::scanOrder    charMode;
  gtiaScanPkg::lineRepeat   numLines;
  logic [`GTIA_X_BITS-1:0]  width;
  logic [`GTIA_Y_BITS-1:0]  height;
  logic                     DLISTend;
  logic [`GTIA_BUF_BITS-1:0]  dBufData;
  logic [`GTIA_ADDR_BITS-1:0] dBufAddr;
  logic                     dBufWriteEn;
  logic                     hblank;
  logic                     vblank;
  logic [`GTIA_X_BITS-1:0]  x;
  logic [`GTIA_Y_BITS-1:0]  y;

  integer               seed;
  stimEntry             stimTable [$];
  expWrite              expQ [$];
  expWrite              gotExp;
  gtiaRegPkg::colorByte colorRegs [5];
  int                   modelX;
  int                   modelY;
  int                   errorCount;
  int                   writeCount;
  int                   limitCycles;
  int                   negCount;
  bit                   started;

  tbClock clkGen (
    .Fphi0 (Fphi0),
    .rst   (rst)
  );

  gtiaVideo i_dut (
    .Fphi0 (Fphi0), .rst (rst), .AN (AN), .PRIOR (PRIOR),
    .COLBK (COLBK), .COLPF0 (COLPF0), .COLPF1 (COLPF1), .COLPF2 (COLPF2), .COLPF3 (COLPF3),
    .charMode (charMode), .numLines (numLines), .width (width), .height (height),
    .DLISTend (DLISTend), .dBufData (dBufData), .dBufAddr (dBufAddr),
    .dBufWriteEn (dBufWriteEn), .hblank (hblank), .vblank (vblank), .x (x), .y (y)
  );

  task automatic compareVal(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      errorCount++;
      $display("ERR %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  // Each channel of the hue base scaled by (lum + 1) / 8
  function automatic logic [31:0] expRgb(input gtiaRegPkg::colorByte c);
    logic [23:0] base;
    logic [31:0] res;
    int          chan;
    base = gtiaRegPkg::hueBase[c.hue];
    res  = 32'd0;
    for (int ch = 0; ch < 3; ch++) begin
      chan = int'(base[ch*8 +: 8]);
      res  = res | (32'((chan * (int'(c.lum) + 1)) / 8) << (ch * 8));
    end
    return res;
  endfunction

  // Last position of a row group
  // Order 3 walks as line order and repeats 4 and 8 as one
  function automatic bit rowGroupEnd(input logic [1:0] order, input logic [1:0] rep,
                                     input int w, input int px, input int py);
    if (px != w - 1) return 1'b0;
    if (order == 2'd1) return (py % 8) == 7;
    if (order == 2'd2) return (py % 16) == 15;
    if (rep == 2'd1) return (py % 2) == 1;
    return 1'b1;
  endfunction

  function automatic void nextPos(input logic [1:0] order, input logic [1:0] rep,
                                  input int w, input int h, input int px, input int py,
                                  output int nx, output int ny);
    nx = px + 1;
    ny = py;
    if (px == w - 1 && py == h - 1) begin
      nx = 0;
      ny = 0;
    end else if (rowGroupEnd(order, rep, w, px, py)) begin
      nx = 0;
      ny = py + 1;
    end else if (order == 2'd1) begin
      // 8 across a block row, then the next row, then the block to the right
      if (px % 8 == 7 && py % 8 == 7) begin
        ny = py - 7;
      end else if (px % 8 == 7) begin
        nx = px - 7;
        ny = py + 1;
      end
    end else if (order == 2'd2 || rep == 2'd1) begin
      if (py % 2 == 0) begin
        nx = px;
        ny = py + 1;
      end else if (order == 2'd2 && px % 16 == 15 && py % 16 == 15) begin
        ny = py - 15;
      end else if (order == 2'd2 && px % 16 == 15) begin
        nx = px - 15;
        ny = py + 1;
      end else begin
        ny = py - 1;
      end
    end
  endfunction

  task automatic pushExpected(input stimEntry e);
    expWrite item;
    item.name = e.name;
    item.data = expRgb(colorRegs[e.an - 4'd4]);
    item.addr = 32'(modelY * e.w + modelX);
    item.x    = 32'(modelX);
    item.y    = 32'(modelY);
    item.hb   = 32'(rowGroupEnd(e.order, e.rep, e.w, modelX, modelY));
    item.vb   = 32'(modelX == e.w - 1 && modelY == e.h - 1);
    // AN is sampled on the next edge and the write registered on the one after
    item.due  = negCount + 3;
    expQ.push_back(item);
  endtask

  task automatic addEntry(input string name, input logic [3:0] an, input logic [7:0] prior,
                          input logic [1:0] order, input logic [1:0] rep, input int w,
                          input int h, input bit dlist, input int burst);
    stimEntry s;
    s.name  = name;
    s.an    = an;
    s.prior = prior;
    s.order = order;
    s.rep   = rep;
    s.w     = w;
    s.h     = h;
    s.dlist = dlist;
    s.burst = burst;
    stimTable.push_back(s);
  endtask

  task automatic applyEntry(input stimEntry e);
    logic [31:0] rnd;
    int          nx;
    int          ny;
    // Two idle cycles drain the pixels in flight under the old configuration
    @(posedge Fphi0);
    AN       <= gtiaRegPkg::noTransmission;
    DLISTend <= 1'b0;
    for (int k = 0; k < 5; k++) begin
      rnd          = $random(seed);
      colorRegs[k] = rnd[7:0];
    end
    COLBK  <= colorRegs[0];
    COLPF0 <= colorRegs[1];
    COLPF1 <= colorRegs[2];
    COLPF2 <= colorRegs[3];
    COLPF3 <= colorRegs[4];
    @(posedge Fphi0);
    if (e.dlist) begin
      modelX = 0;
      modelY = 0;
    end
    for (int i = 0; i < e.burst; i++) begin
      @(posedge Fphi0);
      AN       <= gtiaRegPkg::anCode'(e.an);
      PRIOR    <= e.prior;
      charMode <= gtiaScanPkg::scanOrder'(e.order);
      numLines <= gtiaScanPkg::lineRepeat'(e.rep);
      width    <= `GTIA_X_BITS'(e.w);
      height   <= `GTIA_Y_BITS'(e.h);
      DLISTend <= e.dlist;
      if (e.prior[7:6] == gtiaRegPkg::modeNormal && e.an >= 4'd4 && e.an <= 4'd8) begin
        pushExpected(e);
        nextPos(e.order, e.rep, e.w, e.h, modelX, modelY, nx, ny);
        modelX = nx;
        modelY = ny;
      end
    end
  endtask

  task automatic buildTable();
    addEntry("restart line one",  4'd0, 8'h00, 2'd0, 2'd0, 16, 4, 1'b1, 1);
    addEntry("bg color",          4'd4, 8'h00, 2'd0, 2'd0, 16, 4, 1'b0, 2);
    addEntry("playfield0",        4'd5, 8'h00, 2'd0, 2'd0, 16, 4, 1'b0, 2);
    addEntry("playfield1",        4'd6, 8'h00, 2'd0, 2'd0, 16, 4, 1'b0, 2);
    addEntry("playfield2",        4'd7, 8'h00, 2'd0, 2'd0, 16, 4, 1'b0, 2);
    addEntry("playfield3",        4'd8, 8'h00, 2'd0, 2'd0, 16, 4, 1'b0, 2);
    addEntry("no transmission",   4'd0, 8'h00, 2'd0, 2'd0, 16, 4, 1'b0, 2);
    addEntry("vsync",             4'd1, 8'h00, 2'd0, 2'd0, 16, 4, 1'b0, 1);
    addEntry("hblank c40",        4'd2, 8'h00, 2'd0, 2'd0, 16, 4, 1'b0, 1);
    addEntry("hblank s40",        4'd3, 8'h00, 2'd0, 2'd0, 16, 4, 1'b0, 1);
    addEntry("unused code 9",     4'd9, 8'h00, 2'd0, 2'd0, 16, 4, 1'b0, 1);
    addEntry("unused code 15",    4'd15, 8'h00, 2'd0, 2'd0, 16, 4, 1'b0, 1);
    addEntry("gtia mode 1",       4'd5, 8'h40, 2'd0, 2'd0, 16, 4, 1'b0, 3);
    addEntry("gtia mode 2",       4'd8, 8'h80, 2'd0, 2'd0, 16, 4, 1'b0, 2);
    addEntry("gtia mode 3",       4'd4, 8'hC0, 2'd0, 2'd0, 16, 4, 1'b0, 3);
    addEntry("line one frame",    4'd7, 8'h00, 2'd0, 2'd0, 16, 4, 1'b0, 60);
    addEntry("restart line two",  4'd0, 8'h00, 2'd0, 2'd1, 16, 4, 1'b1, 1);
    addEntry("line two frame",    4'd4, 8'h00, 2'd0, 2'd1, 16, 4, 1'b0, 70);
    addEntry("dlist mid frame",   4'd0, 8'h00, 2'd0, 2'd1, 16, 4, 1'b1, 2);
    addEntry("after dlist",       4'd5, 8'h00, 2'd0, 2'd1, 16, 4, 1'b0, 3);
    addEntry("restart block8",    4'd0, 8'h00, 2'd1, 2'd0, 32, 16, 1'b1, 1);
    addEntry("block8 frame",      4'd6, 8'h00, 2'd1, 2'd0, 32, 16, 1'b0, 520);
    addEntry("restart block16",   4'd0, 8'h00, 2'd2, 2'd0, 32, 16, 1'b1, 1);
    addEntry("block16 frame",     4'd7, 8'h00, 2'd2, 2'd0, 32, 16, 1'b0, 520);
    addEntry("restart order 3",   4'd0, 8'h00, 2'd3, 2'd2, 16, 4, 1'b1, 1);
    addEntry("order 3 repeat 4",  4'd8, 8'h00, 2'd3, 2'd2, 16, 4, 1'b0, 20);
  endtask

  // Every write pops the oldest expected pixel
  always @(negedge Fphi0) begin
    negCount++;
    if (started) begin
      if (dBufWriteEn) begin
        writeCount++;
        if (expQ.size() == 0) begin
          errorCount++;
          $display("Buffer write to address %0h arrived with no pixel expected", dBufAddr);
        end else begin
          gotExp = expQ.pop_front();
          compareVal({gotExp.name, " cycle"}, 32'(gotExp.due), 32'(negCount));
          compareVal({gotExp.name, " data"}, gotExp.data, dBufData);
          compareVal({gotExp.name, " addr"}, gotExp.addr, 32'(dBufAddr));
          compareVal({gotExp.name, " x"}, gotExp.x, 32'(x));
          compareVal({gotExp.name, " y"}, gotExp.y, 32'(y));
          compareVal({gotExp.name, " hblank"}, gotExp.hb, 32'(hblank));
          compareVal({gotExp.name, " vblank"}, gotExp.vb, 32'(vblank));
        end
      end else begin
        compareVal("idle hblank", 32'd0, 32'(hblank));
        compareVal("idle vblank", 32'd0, 32'(vblank));
      end
    end
  end

  initial begin
    seed        = 32'h69b8_c094;
    errorCount  = 0;
    writeCount  = 0;
    negCount    = 0;
    started     = 1'b0;
    modelX      = 0;
    modelY      = 0;
    limitCycles = 0;
    AN       <= gtiaRegPkg::noTransmission;
    PRIOR    <= 8'h00;
    COLBK    <= 8'h00;
    COLPF0   <= 8'h00;
    COLPF1   <= 8'h00;
    COLPF2   <= 8'h00;
    COLPF3   <= 8'h00;
    charMode <= gtiaScanPkg::lineOrder;
    numLines <= gtiaScanPkg::one;
    width    <= `GTIA_X_BITS'(16);
    height   <= `GTIA_Y_BITS'(4);
    DLISTend <= 1'b0;
    buildTable();
    limitCycles = 60;
    foreach (stimTable[i]) limitCycles += stimTable[i].burst + 2;
    wait (rst === 1'b1);
    wait (rst === 1'b0);
    @(negedge Fphi0);
    compareVal("reset write enable", 32'd0, 32'(dBufWriteEn));
    compareVal("reset hblank", 32'd0, 32'(hblank));
    compareVal("reset vblank", 32'd0, 32'(vblank));
    compareVal("reset x", 32'd0, 32'(x));
    compareVal("reset y", 32'd0, 32'(y));
    started = 1'b1;
    foreach (stimTable[i]) applyEntry(stimTable[i]);
    // Trailing idle entry flushes the last burst
    applyEntry('{"drain", 4'd0, 8'h00, 2'd0, 2'd0, 16, 4, 1'b0, 2});
    @(negedge Fphi0);
    if (expQ.size() != 0) begin
      errorCount++;
      $display("%0d expected buffer writes never arrived", expQ.size());
    end
    $display("Writes checked: %0d, errors: %0d", writeCount, errorCount);
    if (errorCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog sized from the table once it is built
  initial begin
    wait (limitCycles > 0);
    #(limitCycles * 20);
    $display("Timeout: run did not finish within %0d cycles", limitCycles);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+hdl
hdl/gtiaRegPkg.sv
hdl/gtiaScanPkg.sv
hdl/gtiaIf.sv
hdl/anDecoder.sv
hdl/colorTable.sv
hdl/scanWalker.sv
hdl/bufferWriter.sv
hdl/gtiaVideo.sv
tb/tbClock.sv
tb/gtiaVideoTb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module gtiaVideoTb \
  -f files.f --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

echo "Simulation passed"
exit 0
